// File: decode_ctrl_decoder.sv
// RV32I control decoder
module decode_ctrl_decoder import decode_isa_pkg::*, decode_pipe_pkg::*; (
    input  logic [31:0]           i_instr,
    input  logic                  i_error,  // Fetch error on this word
    output logic [REG_ADDR_W-1:0] o_rs1_addr,
    output logic [REG_ADDR_W-1:0] o_rs2_addr,
    decode_ctrl_if.dec            ctrl
);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic                  legal;
    logic                  trap;
    fu_e                   fu;
    logic [UOP_W-1:0]      uop;
    logic [REG_ADDR_W-1:0] rd;
    opr_route_e            route;
    logic                  rs1_used;
    logic                  rs2_used;

    assign opcode = opcode_e'(i_instr[6:2]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    // Shared by register and immediate ALU forms
    function automatic alu_uop_e alu_uop(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: alu_uop = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_uop = ALU_SLL;
            F3_SLT:     alu_uop = ALU_SLT;
            F3_SLTU:    alu_uop = ALU_SLTU;
            F3_XOR:     alu_uop = ALU_XOR;
            F3_SRL_SRA: alu_uop = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_uop = ALU_OR;
            F3_AND:     alu_uop = ALU_AND;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Instruction classification
    // ------------------------------------------------------------------------
    always_comb begin
        legal = 1'b1;
        fu    = FU_NONE;
        uop   = '0;
        route = R_NONE;
        rd    = i_instr[11:7];
        case (opcode)
            OPC_OP: begin
                fu    = FU_ALU;
                route = R_RR;
                uop   = alu_uop(funct3, funct7[5]);
                legal = (funct7 == F7_BASE) ||
                        (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
            end
            OPC_OP_IMM: begin
                fu    = FU_ALU;
                route = R_RI;
                uop   = alu_uop(funct3, funct3 == F3_SRL_SRA && funct7[5]); // addi has no sub
                if (funct3 == F3_SLL) begin
                    legal = funct7 == F7_BASE;
                end else if (funct3 == F3_SRL_SRA) begin
                    legal = funct7 == F7_BASE || funct7 == F7_ALT;
                end
            end
            OPC_LUI: begin
                fu    = FU_ALU;
                uop   = ALU_OR;                 // Zero OR imm
                route = R_LUI;
            end
            OPC_AUIPC: begin
                fu    = FU_ALU;
                uop   = ALU_ADD;                // (pc+imm) plus zero
                route = R_AUIPC;
            end
            OPC_BRANCH: begin
                fu    = FU_CFU;
                route = R_BRANCH;
                rd    = REG_ZERO;
                case (funct3)
                    F3_BEQ:  uop = CFU_BEQ;
                    F3_BNE:  uop = CFU_BNE;
                    F3_BLT:  uop = CFU_BLT;
                    F3_BGE:  uop = CFU_BGE;
                    F3_BLTU: uop = CFU_BLTU;
                    F3_BGEU: uop = CFU_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_JAL: begin
                fu    = FU_CFU;
                uop   = CFU_JALI;
                route = R_JAL;
            end
            OPC_JALR: begin
                fu    = FU_CFU;
                uop   = CFU_JALR;
                route = R_RI;
                legal = funct3 == F3_JALR;
            end
            OPC_LOAD: begin
                fu    = FU_LSU;
                route = R_RI;
                case (funct3)
                    F3_BYTE:  uop = LSU_LB;
                    F3_HALF:  uop = LSU_LH;
                    F3_WORD:  uop = LSU_LW;
                    F3_BYTEU: uop = LSU_LBU;
                    F3_HALFU: uop = LSU_LHU;
                    default:  legal = 1'b0;
                endcase
            end
            OPC_STORE: begin
                fu    = FU_LSU;
                route = R_STORE;
                rd    = REG_ZERO;
                case (funct3)
                    F3_BYTE: uop = LSU_SB;
                    F3_HALF: uop = LSU_SH;
                    F3_WORD: uop = LSU_SW;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase

        if (i_instr[1:0] != OPC_LEN32) begin
            legal = 1'b0;                       // Compressed words not supported
        end

        // Fetch error wins over an illegal encoding
        trap = i_error || !legal;
        if (trap) begin
            fu    = FU_NONE;
            uop   = '0;
            route = R_NONE;
            rd    = i_error ? TRAP_IACCESS : TRAP_IOPCODE;
        end
    end

    // ------------------------------------------------------------------------
    // Register file read addresses
    // ------------------------------------------------------------------------
    assign rs1_used   = route inside {R_RR, R_RI, R_STORE, R_BRANCH};
    assign rs2_used   = route inside {R_RR, R_STORE, R_BRANCH};
    assign o_rs1_addr = rs1_used ? i_instr[19:15] : REG_ZERO;
    assign o_rs2_addr = rs2_used ? i_instr[24:20] : REG_ZERO;

    assign ctrl.fu    = fu;
    assign ctrl.uop   = uop;
    assign ctrl.rd    = rd;
    assign ctrl.trap  = trap;
    assign ctrl.route = route;

endmodule

// File: decode_ctrl_if.sv
// Decoded control bundle
interface decode_ctrl_if import decode_isa_pkg::*, decode_pipe_pkg::*; ();

    fu_e                   fu;
    logic [UOP_W-1:0]      uop;
    logic [REG_ADDR_W-1:0] rd;    // Holds trap cause when trap is set
    logic                  trap;
    opr_route_e            route;

    modport dec (
        output fu, uop, rd, trap, route
    );

    modport opnd (
        input route
    );

    modport sreg (
        input fu, uop, rd, trap
    );

endinterface

// File: decode_isa_pkg.sv
// RV32I encoding constants
package decode_isa_pkg;

    localparam int XLEN       = 32;    // Data path width
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0]       PC_RESET_VALUE = 32'h8000_0000;
    localparam logic [REG_ADDR_W-1:0] REG_ZERO       = 5'd0;
    localparam logic [1:0]            OPC_LEN32      = 2'b11; // Low bits of a 32-bit word

    // ------------------------------------------------------------------------
    // Major opcodes, instruction bits 6:2
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        OPC_LOAD   = 5'b00000,
        OPC_OP_IMM = 5'b00100,
        OPC_AUIPC  = 5'b00101,
        OPC_STORE  = 5'b01000,
        OPC_OP     = 5'b01100,
        OPC_LUI    = 5'b01101,
        OPC_BRANCH = 5'b11000,
        OPC_JALR   = 5'b11001,
        OPC_JAL    = 5'b11011
    } opcode_e;

    // ------------------------------------------------------------------------
    // funct3 and funct7 fields
    // ------------------------------------------------------------------------
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [2:0] F3_BYTE  = 3'b000; // Also LB, SB
    localparam logic [2:0] F3_HALF  = 3'b001; // Also LH, SH
    localparam logic [2:0] F3_WORD  = 3'b010; // Also LW, SW
    localparam logic [2:0] F3_BYTEU = 3'b100;
    localparam logic [2:0] F3_HALFU = 3'b101;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA(I)

    typedef enum logic [4:0] {
        TRAP_IACCESS = 5'd1, // Fetch access fault
        TRAP_IOPCODE = 5'd2  // Illegal instruction
    } trap_cause_e;

endpackage

// File: decode_operand_builder.sv
// Immediates, program counter and operands
module decode_operand_builder import decode_isa_pkg::*, decode_pipe_pkg::*; (
    input  logic            g_clk,
    input  logic            g_resetn,
    input  logic [31:0]     i_instr,
    input  logic            i_accept,     // Instruction taken this cycle
    input  logic            i_cf_req,
    input  logic            i_cf_ack,
    input  logic [XLEN-1:0] i_cf_target,
    input  logic [XLEN-1:0] i_rs1_rdata,
    input  logic [XLEN-1:0] i_rs2_rdata,
    decode_ctrl_if.opnd     ctrl,
    output logic [XLEN-1:0] o_opr_a,
    output logic [XLEN-1:0] o_opr_b,
    output logic [XLEN-1:0] o_opr_c
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_imm;
    logic [XLEN-1:0] pc_plus_imm;

    // ------------------------------------------------------------------------
    // Immediate extraction
    // ------------------------------------------------------------------------
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    // ------------------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= PC_RESET_VALUE;
        end else if (i_cf_req && i_cf_ack) begin
            pc <= i_cf_target;                  // Redirect has priority
        end else if (i_accept) begin
            pc <= pc + XLEN'(4);
        end
    end

    always_comb begin
        case (ctrl.route)
            R_BRANCH: pc_imm = imm_b;
            R_JAL:    pc_imm = imm_j;
            default:  pc_imm = imm_u;           // AUIPC
        endcase
    end

    assign pc_plus_imm = pc + pc_imm;

    // Unused operands load as zero
    always_comb begin
        o_opr_a = '0;
        o_opr_b = '0;
        o_opr_c = '0;
        case (ctrl.route)
            R_RR: begin
                o_opr_a = i_rs1_rdata;
                o_opr_b = i_rs2_rdata;
            end
            R_RI: begin
                o_opr_a = i_rs1_rdata;
                o_opr_b = imm_i;
            end
            R_STORE: begin
                o_opr_a = i_rs1_rdata;
                o_opr_b = imm_s;
                o_opr_c = i_rs2_rdata;          // Store data
            end
            R_BRANCH: begin
                o_opr_a = i_rs1_rdata;
                o_opr_b = i_rs2_rdata;
                o_opr_c = pc_plus_imm;          // Branch target
            end
            R_JAL:   o_opr_c = pc_plus_imm;
            R_LUI:   o_opr_b = imm_u;
            R_AUIPC: o_opr_a = pc_plus_imm;
            default: ;
        endcase
    end

    pc_aligned_a: assert property (@(posedge g_clk) disable iff (!g_resetn)
        ((i_cf_req && i_cf_ack) ? (i_cf_target[1:0] == 2'b00) : (pc[1:0] == 2'b00))
        |=> (pc[1:0] == 2'b00))
        else $error("program counter lost word alignment");

endmodule

// File: decode_pipe_pkg.sv
// Pipeline encodings of decode
package decode_pipe_pkg;

    localparam int FU_W    = 2;
    localparam int UOP_W   = 5;
    localparam int ROUTE_W = 4;

    typedef enum logic [FU_W-1:0] {
        FU_NONE, // Nothing to execute, or a trap
        FU_ALU,
        FU_CFU,  // Branches and jumps
        FU_LSU
    } fu_e;

    typedef enum logic [UOP_W-1:0] {
        ALU_ADD = 5'd0, ALU_SUB  = 5'd1, ALU_AND = 5'd2, ALU_OR  = 5'd3,
        ALU_XOR = 5'd4, ALU_SLT  = 5'd5, ALU_SLTU = 5'd6, ALU_SLL = 5'd7,
        ALU_SRL = 5'd8, ALU_SRA  = 5'd9
    } alu_uop_e;

    typedef enum logic [UOP_W-1:0] {
        CFU_BEQ  = 5'd0, CFU_BNE  = 5'd1, CFU_BLT  = 5'd2, CFU_BGE  = 5'd3,
        CFU_BLTU = 5'd4, CFU_BGEU = 5'd5, CFU_JALI = 5'd6, CFU_JALR = 5'd7
    } cfu_uop_e;

    typedef enum logic [UOP_W-1:0] {
        LSU_LB  = 5'd0, LSU_LH  = 5'd1, LSU_LW = 5'd2, LSU_LBU = 5'd3,
        LSU_LHU = 5'd4, LSU_SB  = 5'd5, LSU_SH = 5'd6, LSU_SW  = 5'd7
    } lsu_uop_e;

    // ------------------------------------------------------------------------
    // Operand routing, listed as operand A, B, C
    // ------------------------------------------------------------------------
    typedef enum logic [ROUTE_W-1:0] {
        R_RR,     // rs1, rs2, zero
        R_RI,     // rs1, imm, zero
        R_STORE,  // rs1, imm, rs2
        R_BRANCH, // rs1, rs2, pc+imm
        R_JAL,    // zero, zero, pc+imm
        R_LUI,    // zero, imm, zero
        R_AUIPC,  // pc+imm, zero, zero
        R_NONE    // All zero
    } opr_route_e;

endpackage

// File: decode_stage_reg.sv
// Decode output pipeline register
module decode_stage_reg import decode_isa_pkg::*, decode_pipe_pkg::*; (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  i_valid,
    input  logic                  i_flush,
    input  logic                  i_busy,    // Next stage stalled
    output logic                  o_busy,
    output logic                  o_valid,
    output logic                  o_accept,  // Input taken this cycle
    decode_ctrl_if.sreg           ctrl,
    input  logic [XLEN-1:0]       i_opr_a,
    input  logic [XLEN-1:0]       i_opr_b,
    input  logic [XLEN-1:0]       i_opr_c,
    output logic [XLEN-1:0]       o_opr_a,
    output logic [XLEN-1:0]       o_opr_b,
    output logic [XLEN-1:0]       o_opr_c,
    output fu_e                   o_fu,
    output logic [UOP_W-1:0]      o_uop,
    output logic [REG_ADDR_W-1:0] o_rd,
    output logic                  o_trap
);

    assign o_busy   = o_valid && i_busy;
    assign o_accept = i_valid && !o_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;
        end else if (!o_busy) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (o_accept) begin
            o_fu    <= ctrl.fu;
            o_uop   <= ctrl.uop;
            o_rd    <= ctrl.rd;
            o_trap  <= ctrl.trap;
            o_opr_a <= i_opr_a;
            o_opr_b <= i_opr_b;
            o_opr_c <= i_opr_c;
        end
    end

    // Stalled output keeps its payload, and stays valid unless flushed
    hold_on_stall_a: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (o_valid && i_busy) |=>
            $stable({o_fu, o_uop, o_rd, o_trap, o_opr_a, o_opr_b, o_opr_c}) &&
            (o_valid || $past(i_flush)))
        else $error("decode output changed while stalled");

endmodule

// File: decode_trace.txt
# instr err rs1_data rs2_data flush cf_req cf_target stall_max
# exp: rs1_addr rs2_addr fu uop rd trap opr_a opr_b opr_c (all hex)
002081B3 0 11111111 22222222 0 0 0 3 1 2 1 0 3 0 11111111 22222222 0
407302B3 0 64 14 0 0 0 0 6 7 1 1 5 0 64 14 0
40A4D433 0 F0000000 4 0 0 0 2 9 A 1 9 8 0 F0000000 4 0
FFF10093 0 10 DEADBEEF 0 0 0 0 2 0 1 0 1 0 10 FFFFFFFF 0
40325213 0 80000000 DEADBEEF 0 0 0 1 4 0 1 9 4 0 80000000 403 0
123453B7 0 AAAAAAAA BBBBBBBB 0 0 0 0 0 0 1 3 7 0 0 12345000 0
00001497 0 AAAAAAAA BBBBBBBB 0 0 0 0 0 0 1 0 9 0 80001018 0 0
00812583 0 1000 BBBBBBBB 0 0 0 0 2 0 3 2 B 0 1000 8 0
FFC1C603 0 2000 BBBBBBBB 0 0 0 2 3 0 3 3 C 0 2000 FFFFFFFC 0
00532623 0 3000 CAFEF00D 0 0 0 0 6 5 3 7 0 0 3000 C CAFEF00D
FE741F23 0 100 BEEF 0 0 0 0 8 7 3 6 0 0 100 FFFFFFFE BEEF
00208863 0 5 5 0 0 0 1 1 2 2 0 0 0 5 5 8000003C
FE41ECE3 0 1 2 0 0 0 0 3 4 2 4 0 0 1 2 80000028
100000EF 0 AAAAAAAA BBBBBBBB 0 0 0 0 0 0 2 6 1 0 0 0 80000134
00408067 0 80000100 BBBBBBBB 0 0 0 0 1 0 2 7 0 0 80000100 4 0
FFFFF117 0 AAAAAAAA BBBBBBBB 0 1 90000000 0 0 0 1 0 2 0 8FFFF000 0 0
00629463 0 7 8 0 0 0 2 5 6 2 1 0 0 7 8 9000000C
002081B3 0 1 2 1 0 0 0 1 2 1 0 3 0 1 2 0
002081B3 1 11111111 22222222 0 0 0 0 0 0 0 0 1 1 0 0 0
00000073 0 11111111 22222222 0 0 0 1 0 0 0 0 2 1 0 0 0
FFFFFFFF 1 11111111 22222222 0 0 0 0 0 0 0 0 1 1 0 0 0
00004501 0 11111111 22222222 0 0 0 0 0 0 0 0 2 1 0 0 0
00000497 0 AAAAAAAA BBBBBBBB 0 0 0 2 0 0 1 0 9 0 9000001C 0 0
022081B3 0 11111111 22222222 0 0 0 0 0 0 0 0 2 1 0 0 0

// File: frv_decode_top.sv
// RV32I decode stage
module frv_decode_top import decode_isa_pkg::*, decode_pipe_pkg::*; (
    input  logic                  g_clk,
    input  logic                  g_resetn,

    input  logic                  i_s1_valid,
    output logic                  o_s1_busy,
    input  logic [31:0]           i_s1_data,
    input  logic                  i_s1_error,
    input  logic                  i_s1_flush,
    output logic [REG_ADDR_W-1:0] o_s1_rs1_addr,
    output logic [REG_ADDR_W-1:0] o_s1_rs2_addr,
    input  logic [XLEN-1:0]       i_s1_rs1_rdata,
    input  logic [XLEN-1:0]       i_s1_rs2_rdata,

    input  logic                  i_cf_req,
    input  logic [XLEN-1:0]       i_cf_target,
    input  logic                  i_cf_ack,

    output logic                  o_s2_valid,
    input  logic                  i_s2_busy,
    output logic [REG_ADDR_W-1:0] o_s2_rd,
    output logic [XLEN-1:0]       o_s2_opr_a,
    output logic [XLEN-1:0]       o_s2_opr_b,
    output logic [XLEN-1:0]       o_s2_opr_c,
    output logic [UOP_W-1:0]      o_s2_uop,
    output fu_e                   o_s2_fu,
    output logic                  o_s2_trap
);

    logic            accept;
    logic [XLEN-1:0] opr_a;
    logic [XLEN-1:0] opr_b;
    logic [XLEN-1:0] opr_c;

    decode_ctrl_if ctrl_if ();

    decode_ctrl_decoder decoder_i (
        .i_instr     (i_s1_data),
        .i_error     (i_s1_error),
        .o_rs1_addr  (o_s1_rs1_addr),
        .o_rs2_addr  (o_s1_rs2_addr),
        .ctrl        (ctrl_if.dec)
    );

    decode_operand_builder operand_builder_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_instr     (i_s1_data),
        .i_accept    (accept),
        .i_cf_req    (i_cf_req),
        .i_cf_ack    (i_cf_ack),
        .i_cf_target (i_cf_target),
        .i_rs1_rdata (i_s1_rs1_rdata),
        .i_rs2_rdata (i_s1_rs2_rdata),
        .ctrl        (ctrl_if.opnd),
        .o_opr_a     (opr_a),
        .o_opr_b     (opr_b),
        .o_opr_c     (opr_c)
    );

    decode_stage_reg stage_reg_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .i_valid     (i_s1_valid),
        .i_flush     (i_s1_flush),
        .i_busy      (i_s2_busy),
        .o_busy      (o_s1_busy),
        .o_valid     (o_s2_valid),
        .o_accept    (accept),          // Steps the program counter
        .ctrl        (ctrl_if.sreg),
        .i_opr_a     (opr_a),
        .i_opr_b     (opr_b),
        .i_opr_c     (opr_c),
        .o_opr_a     (o_s2_opr_a),
        .o_opr_b     (o_s2_opr_b),
        .o_opr_c     (o_s2_opr_c),
        .o_fu        (o_s2_fu),
        .o_uop       (o_s2_uop),
        .o_rd        (o_s2_rd),
        .o_trap      (o_s2_trap)
    );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the decode stage simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_decode -o tb_decode_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_decode_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

// File: sim.f
decode_isa_pkg.sv
decode_pipe_pkg.sv
decode_ctrl_if.sv
decode_ctrl_decoder.sv
decode_operand_builder.sv
decode_stage_reg.sv
frv_decode_top.sv
tb_decode.sv

// File: tb_decode.sv
// Decode stage testbench
module tb_decode;

    localparam int MAX_RECORDS = 64;
    localparam int NUM_FIELDS  = 17;

    // Column positions in a trace record
    localparam int F_INSTR = 0;
    localparam int F_ERR   = 1;
    localparam int F_RS1D  = 2;
    localparam int F_RS2D  = 3;
    localparam int F_FLUSH = 4;
    localparam int F_CF    = 5;
    localparam int F_TGT   = 6;
    localparam int F_STALL = 7;
    localparam int F_RS1   = 8;
    localparam int F_RS2   = 9;
    localparam int F_FU    = 10;
    localparam int F_UOP   = 11;
    localparam int F_RD    = 12;
    localparam int F_TRAP  = 13;
    localparam int F_A     = 14;
    localparam int F_B     = 15;
    localparam int F_C     = 16;

    logic        g_clk;
    logic        g_resetn;
    logic        i_s1_valid;
    logic        o_s1_busy;
    logic [31:0] i_s1_data;
    logic        i_s1_error;
    logic        i_s1_flush;
    logic [4:0]  o_s1_rs1_addr;
    logic [4:0]  o_s1_rs2_addr;
    logic [31:0] i_s1_rs1_rdata;
    logic [31:0] i_s1_rs2_rdata;
    logic        i_cf_req;
    logic [31:0] i_cf_target;
    logic        i_cf_ack;
    logic        o_s2_valid;
    logic        i_s2_busy;
    logic [4:0]  o_s2_rd;
    logic [31:0] o_s2_opr_a;
    logic [31:0] o_s2_opr_b;
    logic [31:0] o_s2_opr_c;
    logic [4:0]  o_s2_uop;
    logic [1:0]  o_s2_fu;
    logic        o_s2_trap;

    logic [31:0] trace [0:MAX_RECORDS-1][0:NUM_FIELDS-1];
    int          num_records;
    logic [31:0] rng_state;
    int          watchdog_cycles;
    logic        watchdog_armed = 1'b0;
    logic        s2_valid_exp;             // Model of o_s2_valid between records
    int          shown_idx;                // Record expected on s2

    frv_decode_top frv_decode_top_i (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .i_s1_valid     (i_s1_valid),
        .o_s1_busy      (o_s1_busy),
        .i_s1_data      (i_s1_data),
        .i_s1_error     (i_s1_error),
        .i_s1_flush     (i_s1_flush),
        .o_s1_rs1_addr  (o_s1_rs1_addr),
        .o_s1_rs2_addr  (o_s1_rs2_addr),
        .i_s1_rs1_rdata (i_s1_rs1_rdata),
        .i_s1_rs2_rdata (i_s1_rs2_rdata),
        .i_cf_req       (i_cf_req),
        .i_cf_target    (i_cf_target),
        .i_cf_ack       (i_cf_ack),
        .o_s2_valid     (o_s2_valid),
        .i_s2_busy      (i_s2_busy),
        .o_s2_rd        (o_s2_rd),
        .o_s2_opr_a     (o_s2_opr_a),
        .o_s2_opr_b     (o_s2_opr_b),
        .o_s2_opr_c     (o_s2_opr_c),
        .o_s2_uop       (o_s2_uop),
        .o_s2_fu        (o_s2_fu),
        .o_s2_trap      (o_s2_trap)
    );

    always #5 g_clk = ~g_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------------------------------
    // Trace loading, comment lines start with #
    // ------------------------------------------------------------------------
    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        logic [31:0] t [0:NUM_FIELDS-1];
        fd = $fopen("decode_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file decode_trace.txt");
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
        num_records = 0;
        while (!$feof(fd) && num_records < MAX_RECORDS) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7], t[8],
                            t[9], t[10], t[11], t[12], t[13], t[14], t[15], t[16]);
                if (n == NUM_FIELDS) begin
                    for (int k = 0; k < NUM_FIELDS; k++) begin
                        trace[num_records][k] = t[k];
                    end
                    num_records++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_outputs(input int idx, input logic exp_busy);
        check_value($sformatf("record %0d s2_valid", idx), 32'd1, 32'(o_s2_valid));
        check_value($sformatf("record %0d fu", idx), trace[idx][F_FU], 32'(o_s2_fu));
        check_value($sformatf("record %0d uop", idx), trace[idx][F_UOP], 32'(o_s2_uop));
        check_value($sformatf("record %0d rd", idx), trace[idx][F_RD], 32'(o_s2_rd));
        check_value($sformatf("record %0d trap", idx), trace[idx][F_TRAP], 32'(o_s2_trap));
        check_value($sformatf("record %0d opr_a", idx), trace[idx][F_A], o_s2_opr_a);
        check_value($sformatf("record %0d opr_b", idx), trace[idx][F_B], o_s2_opr_b);
        check_value($sformatf("record %0d opr_c", idx), trace[idx][F_C], o_s2_opr_c);
        check_value($sformatf("record %0d s1_busy", idx), 32'(exp_busy), 32'(o_s1_busy));
    endtask

    // ------------------------------------------------------------------------
    // One record: optional redirect, handshake, then output checks
    // ------------------------------------------------------------------------
    task automatic run_record(input int idx);
        int   stall_len;
        logic accepted;
        logic busy_exp;
        stall_len = 0;
        if (trace[idx][F_STALL] != 0) begin
            rng_state = xorshift(rng_state);
            stall_len = 1 + int'(rng_state % trace[idx][F_STALL]);
        end
        if (trace[idx][F_CF] != 0) begin
            @(posedge g_clk);
            i_cf_req    <= 1'b1;
            i_cf_ack    <= 1'b0;            // Request alone must not redirect
            i_cf_target <= ~trace[idx][F_TGT];
            @(posedge g_clk);
            i_cf_ack    <= 1'b1;
            i_cf_target <= trace[idx][F_TGT];
            @(posedge g_clk);
            i_cf_req    <= 1'b0;
            i_cf_ack    <= 1'b0;
        end
        @(posedge g_clk);
        i_s1_valid     <= 1'b1;
        i_s1_data      <= trace[idx][F_INSTR];
        i_s1_error     <= trace[idx][F_ERR][0];
        i_s1_rs1_rdata <= trace[idx][F_RS1D];
        i_s1_rs2_rdata <= trace[idx][F_RS2D];
        i_s2_busy      <= (stall_len > 0);  // Previous output held while this one waits
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge g_clk);
            busy_exp = s2_valid_exp && (stall_len > 0);
            check_value($sformatf("record %0d rs1_addr", idx), trace[idx][F_RS1],
                        32'(o_s1_rs1_addr));
            check_value($sformatf("record %0d rs2_addr", idx), trace[idx][F_RS2],
                        32'(o_s1_rs2_addr));
            check_value($sformatf("record %0d s1_busy", idx), 32'(busy_exp),
                        32'(o_s1_busy));
            if (busy_exp) begin
                check_outputs(shown_idx, 1'b1); // Held under stall
            end
            accepted = !busy_exp;
            if (stall_len > 0) begin
                stall_len--;
            end
            @(posedge g_clk);
            if (stall_len == 0) begin
                i_s2_busy <= 1'b0;
            end
        end
        i_s1_valid <= 1'b0;
        i_s1_flush <= trace[idx][F_FLUSH][0];
        i_s2_busy  <= 1'b1;                 // Keep output until the next record
        @(negedge g_clk);
        check_value($sformatf("record %0d s2_valid", idx), 32'd1, 32'(o_s2_valid));
        if (trace[idx][F_FLUSH] != 0) begin
            @(posedge g_clk);
            i_s1_flush <= 1'b0;
            @(negedge g_clk);
            check_value($sformatf("record %0d flushed valid", idx), 32'd0, 32'(o_s2_valid));
            check_value($sformatf("record %0d flushed busy", idx), 32'd0, 32'(o_s1_busy));
            s2_valid_exp = 1'b0;
        end else begin
            check_outputs(idx, 1'b1);
            s2_valid_exp = 1'b1;
            shown_idx    = idx;
        end
    endtask

    initial begin
        wait (watchdog_armed);
        repeat (watchdog_cycles) @(posedge g_clk);
        $display("timeout: the DUT did not finish the trace in %0d cycles", watchdog_cycles);
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    initial begin
        g_clk          = 1'b0;
        g_resetn       = 1'b0;
        i_s1_valid     = 1'b0;
        i_s1_data      = 32'h0000_0013;
        i_s1_error     = 1'b0;
        i_s1_flush     = 1'b0;
        i_s1_rs1_rdata = 32'd0;
        i_s1_rs2_rdata = 32'd0;
        i_cf_req       = 1'b0;
        i_cf_target    = 32'd0;
        i_cf_ack       = 1'b0;
        i_s2_busy      = 1'b0;
        rng_state      = 32'd10948;
        s2_valid_exp   = 1'b0;
        shown_idx      = 0;

        load_trace();
        watchdog_cycles = num_records * 20 + 100;
        watchdog_armed  = 1'b1;

        repeat (4) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        check_value("reset s2_valid", 32'd0, 32'(o_s2_valid));
        check_value("reset s1_busy", 32'd0, 32'(o_s1_busy));

        for (int i = 0; i < num_records; i++) begin
            run_record(i);
        end
        @(posedge g_clk);
        i_s2_busy <= 1'b0;

        if (num_records == 0) begin
            $display("trace file held no records");
            $display("SOME TESTS FAILED");
            $fatal(1);
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule
